// ==== Bender.yml ====
package:
  name: tsccore

sources:
  - hdl/tscPkg.sv
  - hdl/stageLink.sv
  - hdl/fetchStage.sv
  - hdl/decodeStage.sv
  - hdl/executeStage.sv
  - hdl/memoryStage.sv
  - hdl/writebackStage.sv
  - hdl/tscCore.sv
  - target: test
    files:
      - verification/clockGen.sv
      - verification/tscCoreTb.sv

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import tscPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  wordT   instData,
    input  wordT   pcNext,
    input  logic   fetchValid,
    output logic   stall,
    output logic   redirect,
    output wordT   redirectPc,
    output logic   haltSeen,
    input  wordT   exResult,
    input  regIdxT exRd,
    input  logic   exWrite,
    input  logic   wbWrite,
    input  regIdxT wbRd,
    input  wordT   wbData,
    stageLink.up   idEx
);

    wordT   regs [4];
    logic   [3:0] op;
    logic   [5:0] fn;
    regIdxT rs;
    regIdxT rt;
    regIdxT dst;
    ctrlT   ctrl;
    aluOpT  aluOp;
    logic   aluSrcImm;
    logic   usesRs;
    logic   usesRt;
    logic   isBranch;
    logic   isJump;
    logic   decValid;
    logic   issue;
    logic   taken;
    logic   loadUse;
    logic   branchHaz;
    logic   memLoad;   // load now sitting in EX/MEM
    regIdxT memLoadRd;
    wordT   imm;
    wordT   rfA;
    wordT   rfB;
    wordT   opA;
    wordT   opB;

    assign op = instData[15:12];
    assign fn = instData[5:0];
    assign rs = instData[11:10];
    assign rt = instData[9:8];
    assign decValid = fetchValid && !haltSeen;
    assign imm = (op == opLhi) ? {instData[7:0], 8'h00} : {{8{instData[7]}}, instData[7:0]};

    always_comb begin
        ctrl = '0;
        aluOp = aluAdd;
        aluSrcImm = 1'b0;
        dst = rt;
        usesRs = 1'b0;
        usesRt = 1'b0;
        isBranch = 1'b0;
        isJump = 1'b0;
        case (op)
            opR: begin
                dst = instData[7:6];
                case (fn)
                    fnAdd, fnSub, fnAnd, fnOrr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.isDone = 1'b1;
                        usesRs = 1'b1;
                        usesRt = 1'b1;
                    end
                    fnWwd: begin
                        ctrl.isWwd = 1'b1;
                        ctrl.isDone = 1'b1;
                        usesRs = 1'b1;
                    end
                    fnHlt: begin
                        ctrl.isHalt = 1'b1;
                        ctrl.isDone = 1'b1;
                    end
                    default: ;
                endcase
                case (fn)
                    fnSub: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOrr: aluOp = aluOr;
                    default: aluOp = aluAdd;
                endcase
            end
            opAdi, opLwd: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = (op == opLwd);
                ctrl.memToReg = (op == opLwd);
                ctrl.isDone = 1'b1;
                aluSrcImm = 1'b1;
                usesRs = 1'b1;
            end
            opLhi: begin
                ctrl.regWrite = 1'b1;
                ctrl.isDone = 1'b1;
                aluOp = aluPassB;
                aluSrcImm = 1'b1;
            end
            opSwd: begin
                ctrl.memWrite = 1'b1;
                ctrl.isDone = 1'b1;
                aluSrcImm = 1'b1;
                usesRs = 1'b1;
                usesRt = 1'b1;
            end
            opBne, opBeq: begin
                ctrl.isDone = 1'b1;
                isBranch = 1'b1;
                usesRs = 1'b1;
                usesRt = 1'b1;
            end
            opJmp: begin
                ctrl.isDone = 1'b1;
                isJump = 1'b1;
            end
            default: ;
        endcase
    end

    // write-through, then EX/MEM result takes priority
    assign rfA = (wbWrite && wbRd == rs) ? wbData : regs[rs];
    assign rfB = (wbWrite && wbRd == rt) ? wbData : regs[rt];
    assign opA = (exWrite && exRd == rs) ? exResult : rfA;
    assign opB = (exWrite && exRd == rt) ? exResult : rfB;

    assign loadUse = idEx.valid && idEx.payload.ctrl.memRead &&
                     ((usesRs && idEx.payload.rd == rs) || (usesRt && idEx.payload.rd == rt));
    assign branchHaz = isBranch &&
                       ((idEx.valid && idEx.payload.ctrl.regWrite &&
                         (idEx.payload.rd == rs || idEx.payload.rd == rt)) ||
                        (memLoad && (memLoadRd == rs || memLoadRd == rt)));
    assign stall = decValid && (loadUse || branchHaz);
    assign issue = decValid && !stall;

    assign taken = (op == opBne) ? (opA != opB) : (opA == opB);
    assign redirect = issue && (isJump || (isBranch && taken));
    assign redirectPc = isJump ? {pcNext[15:12], instData[11:0]} : pcNext + imm;

    always_ff @(posedge clk) begin
        if (wbWrite) begin
            regs[wbRd] <= wbData;
        end
        memLoadRd <= idEx.payload.rd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            haltSeen <= 1'b0;
            memLoad <= 1'b0;
        end else begin
            if (issue && ctrl.isHalt) begin
                haltSeen <= 1'b1;   // ignore everything fetched after HLT
            end
            memLoad <= idEx.valid && idEx.payload.ctrl.memRead;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || idEx.flush) begin
            idEx.valid <= 1'b0;
            idEx.payload.ctrl <= '0;
        end else if (!idEx.stall) begin
            idEx.valid <= issue;   // a stall sends a bubble
            idEx.payload.ctrl <= issue ? ctrl : '0;
            idEx.payload.aluOp <= aluOp;
            idEx.payload.aluSrcImm <= aluSrcImm;
            idEx.payload.rs <= rs;
            idEx.payload.rt <= rt;
            idEx.payload.rd <= dst;
            idEx.payload.opA <= opA;
            idEx.payload.opB <= opB;
            idEx.payload.imm <= imm;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !idEx.valid |-> !idEx.payload.ctrl.regWrite);

endmodule

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import tscPkg::*; (
    input  logic   clk,
    input  logic   rst,
    stageLink.down idEx,
    input  logic   wbWrite,
    input  regIdxT wbRd,
    input  wordT   wbData,
    output wordT   exResult,
    output regIdxT exRd,
    output logic   exWrite,
    stageLink.up   exMem
);

    wordT fwdA;
    wordT fwdB;
    wordT aluB;
    wordT aluOut;

    assign idEx.stall = 1'b0;
    assign idEx.flush = exMem.flush;

    // loads are never forwarded from EX/MEM, their data comes in WB
    assign exResult = exMem.payload.aluResult;
    assign exRd = exMem.payload.rd;
    assign exWrite = exMem.valid && exMem.payload.ctrl.regWrite && !exMem.payload.ctrl.memRead;

    assign fwdA = (exWrite && exRd == idEx.payload.rs) ? exResult :
                  (wbWrite && wbRd == idEx.payload.rs) ? wbData : idEx.payload.opA;
    assign fwdB = (exWrite && exRd == idEx.payload.rt) ? exResult :
                  (wbWrite && wbRd == idEx.payload.rt) ? wbData : idEx.payload.opB;
    assign aluB = idEx.payload.aluSrcImm ? idEx.payload.imm : fwdB;

    always_comb begin
        case (idEx.payload.aluOp)
            aluSub:   aluOut = fwdA - aluB;
            aluAnd:   aluOut = fwdA & aluB;
            aluOr:    aluOut = fwdA | aluB;
            aluPassB: aluOut = aluB;   // LHI
            default:  aluOut = fwdA + aluB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || exMem.flush) begin
            exMem.valid <= 1'b0;
            exMem.payload.ctrl <= '0;
        end else if (!exMem.stall) begin
            exMem.valid <= idEx.valid;
            exMem.payload.ctrl <= idEx.payload.ctrl;
            exMem.payload.rd <= idEx.payload.rd;
            exMem.payload.aluResult <= aluOut;
            exMem.payload.storeData <= fwdB;
            exMem.payload.wwdValue <= fwdA;
        end
    end

endmodule

// ==== hdl/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage import tscPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic redirect,
    input  wordT redirectPc,
    input  logic halt,
    output wordT instAddr,
    output logic instRead,
    output wordT pcNext,
    output logic fetchValid
);

    logic running;
    wordT pc;
    wordT instPc;   // address of the word now on instData

    // on stall re-read the word decode is holding
    assign instAddr = stall ? instPc : pc;
    assign instRead = running && !halt;
    assign pcNext = instPc + 16'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            pc <= '0;
            fetchValid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (redirect) begin
                pc <= redirectPc;
                fetchValid <= 1'b0;   // word in flight is wrong path
            end else if (!stall) begin
                if (instRead) begin
                    pc <= pc + 16'd1;
                end
                fetchValid <= instRead;
            end
        end
    end

    always_ff @(posedge clk) begin
        instPc <= instAddr;
    end

    // a stalled branch cannot be resolved in the same cycle
    assert property (@(posedge clk) disable iff (rst) !(redirect && stall));

endmodule

// ==== hdl/memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage import tscPkg::*; (
    input  logic   clk,
    input  logic   rst,
    stageLink.down exMem,
    output wordT   dataAddr,
    output logic   dataRead,
    output logic   dataWrite,
    output wordT   dataWdata,
    stageLink.up   memWb
);

    assign exMem.stall = 1'b0;
    assign exMem.flush = memWb.flush;   // halt freezes the back end

    assign dataAddr = exMem.payload.aluResult;
    assign dataRead = exMem.valid && exMem.payload.ctrl.memRead;
    assign dataWrite = exMem.valid && exMem.payload.ctrl.memWrite;
    assign dataWdata = exMem.payload.storeData;

    // read data lands in WB, only control and ALU data move here
    always_ff @(posedge clk) begin
        if (rst || memWb.flush) begin
            memWb.valid <= 1'b0;
            memWb.payload.ctrl <= '0;
        end else if (!memWb.stall) begin
            memWb.valid <= exMem.valid;
            memWb.payload.ctrl <= exMem.payload.ctrl;
            memWb.payload.rd <= exMem.payload.rd;
            memWb.payload.aluResult <= exMem.payload.aluResult;
            memWb.payload.wwdValue <= exMem.payload.wwdValue;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(dataRead && dataWrite));

endmodule

// ==== hdl/stageLink.sv ====
`timescale 1ns/1ps

// one pipeline register between two stages
interface stageLink #(
    parameter type payloadT = logic
);
    logic    valid;
    payloadT payload;
    logic    stall;
    logic    flush;   // load a bubble on the next edge

    modport up (
        output valid,
        output payload,
        input  stall,
        input  flush
    );

    modport down (
        input  valid,
        input  payload,
        output stall,
        output flush
    );
endinterface

// ==== hdl/tscCore.sv ====
`timescale 1ns/1ps

module tscCore import tscPkg::*; (
    input  logic clk,
    input  logic rst,
    output wordT instAddr,
    output logic instRead,
    input  wordT instData,
    output wordT dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output wordT dataWdata,
    input  wordT dataRdata,
    output wordT outputPort,
    output logic outputValid,
    output wordT numInst,
    output logic isHalted
);

    wordT   pcNext;
    wordT   redirectPc;
    wordT   exResult;
    wordT   wbData;
    logic   fetchValid;
    logic   stall;
    logic   redirect;
    logic   haltSeen;
    logic   exWrite;
    logic   wbWrite;
    regIdxT exRd;
    regIdxT wbRd;

    stageLink #(.payloadT(idExT))  idExLink ();
    stageLink #(.payloadT(exMemT)) exMemLink ();
    stageLink #(.payloadT(memWbT)) memWbLink ();

    fetchStage fetch (
        .clk, .rst, .stall, .redirect, .redirectPc,
        .halt(haltSeen),   // stop reading once HLT is decoded
        .instAddr, .instRead, .pcNext, .fetchValid
    );

    decodeStage decode (
        .clk, .rst, .instData, .pcNext, .fetchValid,
        .stall, .redirect, .redirectPc, .haltSeen,
        .exResult, .exRd, .exWrite, .wbWrite, .wbRd, .wbData,
        .idEx(idExLink.up)
    );

    executeStage execute (
        .clk, .rst, .idEx(idExLink.down),
        .wbWrite, .wbRd, .wbData,
        .exResult, .exRd, .exWrite,
        .exMem(exMemLink.up)
    );

    memoryStage memory (
        .clk, .rst, .exMem(exMemLink.down),
        .dataAddr, .dataRead, .dataWrite, .dataWdata,
        .memWb(memWbLink.up)
    );

    writebackStage writeback (
        .clk, .rst, .memWb(memWbLink.down), .dataRdata,
        .wbWrite, .wbRd, .wbData,
        .outputPort, .outputValid, .numInst, .isHalted
    );

endmodule

// ==== hdl/tscPkg.sv ====
package tscPkg;

    localparam int wordW = 16;

    typedef logic [wordW-1:0] wordT;
    typedef logic [1:0] regIdxT;

    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opLhi = 4'd6;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [3:0] opR   = 4'd15;

    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluPassB} aluOpT;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic isWwd;
        logic isHalt;
        logic isDone;   // counts as retired in writeback
    } ctrlT;

    typedef struct packed {
        ctrlT   ctrl;
        aluOpT  aluOp;
        logic   aluSrcImm;
        regIdxT rs;
        regIdxT rt;
        regIdxT rd;
        wordT   opA;
        wordT   opB;
        wordT   imm;
    } idExT;

    typedef struct packed {
        ctrlT   ctrl;
        regIdxT rd;
        wordT   aluResult;
        wordT   storeData;
        wordT   wwdValue;
    } exMemT;

    typedef struct packed {
        ctrlT   ctrl;
        regIdxT rd;
        wordT   aluResult;
        wordT   wwdValue;
    } memWbT;

endpackage

// ==== hdl/writebackStage.sv ====
`timescale 1ns/1ps

module writebackStage import tscPkg::*; (
    input  logic   clk,
    input  logic   rst,
    stageLink.down memWb,
    input  wordT   dataRdata,
    output logic   wbWrite,
    output regIdxT wbRd,
    output wordT   wbData,
    output wordT   outputPort,
    output logic   outputValid,
    output wordT   numInst,
    output logic   isHalted
);

    logic live;
    logic wwdNow;

    assign memWb.stall = 1'b0;
    assign memWb.flush = isHalted;

    assign live = memWb.valid && !isHalted;
    assign wwdNow = live && memWb.payload.ctrl.isWwd;

    assign wbWrite = memWb.valid && memWb.payload.ctrl.regWrite;
    assign wbRd = memWb.payload.rd;
    assign wbData = memWb.payload.ctrl.memToReg ? dataRdata : memWb.payload.aluResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            outputPort <= '0;
            outputValid <= 1'b0;
            numInst <= '0;
            isHalted <= 1'b0;
        end else begin
            outputValid <= wwdNow;
            if (wwdNow) begin
                outputPort <= memWb.payload.wwdValue;
            end
            if (live && memWb.payload.ctrl.isDone) begin
                numInst <= numInst + 16'd1;   // HLT itself counts
            end
            if (live && memWb.payload.ctrl.isHalt) begin
                isHalted <= 1'b1;
            end
        end
    end

endmodule

// ==== tscCore.f ====
hdl/tscPkg.sv
hdl/stageLink.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/writebackStage.sv
hdl/tscCore.sv
verification/clockGen.sv
verification/tscCoreTb.sv

// ==== verification/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rst
);

    localparam int resetCycles = 5;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== verification/tscCoreTb.sv ====
`timescale 1ns/1ps

module tscCoreTb;

    localparam int memDepth = 256;
    localparam int vecDepth = 256;
    localparam int progBase = 'h00;
    localparam int dataBase = 'h40;
    localparam int outBase = 'h50;     // count, then test/value pairs
    localparam int storeBase = 'h70;   // count, then address/value pairs
    localparam int countBase = 'h90;   // final numInst, program length
    localparam int haltTail = 10;

    logic        clk;
    logic        rst;
    logic [15:0] instAddr;
    logic        instRead;
    logic [15:0] instData;
    logic [15:0] dataAddr;
    logic        dataRead;
    logic        dataWrite;
    logic [15:0] dataWdata;
    logic [15:0] dataRdata;
    logic [15:0] outputPort;
    logic        outputValid;
    logic [15:0] numInst;
    logic        isHalted;

    logic [15:0] vec [vecDepth];
    logic [15:0] imem [memDepth];
    logic [15:0] dmem [memDepth];
    int errors [1:5];
    int outCount;
    int storeCount;
    int expOut;
    int expStore;
    int progLen;
    int cycles;
    int cycleLimit;
    int passCount;
    int failCount;

    clockGen clocks (.clk, .rst);

    tscCore UUT (
        .clk, .rst, .instAddr, .instRead, .instData,
        .dataAddr, .dataRead, .dataWrite, .dataWdata, .dataRdata,
        .outputPort, .outputValid, .numInst, .isHalted
    );

    // one-cycle synchronous memories
    always @(posedge clk) begin
        if (rst) begin
            instData <= '0;
        end else if (instRead) begin
            instData <= imem[instAddr[7:0]];
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            dataRdata <= '0;
        end else begin
            if (dataRead) begin
                dataRdata <= dmem[dataAddr[7:0]];
            end
            if (dataWrite) begin
                dmem[dataAddr[7:0]] <= dataWdata;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout: core did not halt within %0d cycles", cycleLimit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic compareWord(input int test, input string name,
                               input logic [15:0] got, input logic [15:0] want);
        assert (got === want) else begin
            $display("error at %0t: %s = %h, expected %h", $time, name, got, want);
            errors[test]++;
        end
    endtask

    task automatic checkResetState();
        compareWord(1, "instRead", 16'(instRead), 16'h0000);
        compareWord(1, "dataRead", 16'(dataRead), 16'h0000);
        compareWord(1, "dataWrite", 16'(dataWrite), 16'h0000);
        compareWord(1, "outputValid", 16'(outputValid), 16'h0000);
        compareWord(1, "isHalted", 16'(isHalted), 16'h0000);
        compareWord(1, "numInst", numInst, 16'h0000);
    endtask

    task automatic checkOutput();
        int test;
        assert (outCount < expOut) else begin
            $display("unexpected extra output-port write of %h at %0t", outputPort, $time);
            errors[4]++;
        end
        if (outCount < expOut) begin
            test = vec[outBase + 1 + 2 * outCount];
            compareWord(test, "outputPort", outputPort, vec[outBase + 2 + 2 * outCount]);
        end
        outCount++;
    endtask

    task automatic checkStore();
        assert (storeCount < expStore) else begin
            $display("unexpected extra store to %h at %0t", dataAddr, $time);
            errors[3]++;
        end
        if (storeCount < expStore) begin
            compareWord(3, "dataAddr", dataAddr, vec[storeBase + 1 + 2 * storeCount]);
            compareWord(3, "dataWdata", dataWdata, vec[storeBase + 2 + 2 * storeCount]);
        end
        storeCount++;
    endtask

    task automatic reportTest(input int test, input string name);
        $display("test %0d %s: %s", test, name, errors[test] == 0 ? "passed" : "failed");
        if (errors[test] == 0) begin
            passCount++;
        end else begin
            failCount++;
        end
    endtask

    // outputs sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (isHalted) begin
                assert (!outputValid) else begin
                    $display("output port written after halt at %0t", $time);
                    errors[5]++;
                end
                assert (!dataWrite) else begin
                    $display("store issued after halt at %0t", $time);
                    errors[5]++;
                end
                assert (!instRead) else begin
                    $display("instruction read issued after halt at %0t", $time);
                    errors[5]++;
                end
            end else begin
                if (outputValid) checkOutput();
                if (dataWrite) checkStore();
            end
        end
    end

    initial begin
        instData = '0;
        dataRdata = '0;
        outCount = 0;
        storeCount = 0;
        cycles = 0;
        passCount = 0;
        failCount = 0;
        for (int t = 1; t <= 5; t++) begin
            errors[t] = 0;
        end
        for (int i = 0; i < vecDepth; i++) begin
            vec[i] = '0;
        end
        $readmemh("verification/tscCore_vectors.txt", vec);
        expOut = vec[outBase];
        expStore = vec[storeBase];
        progLen = vec[countBase + 1];
        cycleLimit = 4 * progLen + 50;
        for (int i = 0; i < memDepth; i++) begin
            imem[i] = (i < progLen) ? vec[progBase + i] : 16'(i) ^ 16'hF01D;
            dmem[i] = (i < 16) ? vec[dataBase + i] : {i[7:0], ~i[7:0]};
        end

        @(posedge clk);
        @(negedge clk);
        while (rst) begin
            checkResetState();
            @(negedge clk);
        end
        checkResetState();   // first cycle out of reset
        reportTest(1, "reset");

        while (!isHalted) begin
            @(negedge clk);
        end
        repeat (haltTail) @(negedge clk);

        assert (outCount >= expOut) else begin
            $display("output port wrote %0d values, %0d expected", outCount, expOut);
            errors[vec[outBase + 1 + 2 * outCount]]++;
        end
        assert (storeCount >= expStore) else begin
            $display("data memory saw %0d stores, %0d expected", storeCount, expStore);
            errors[3]++;
        end
        compareWord(5, "numInst", numInst, vec[countBase]);

        reportTest(2, "alu and forwarding");
        reportTest(3, "memory and load-use");
        reportTest(4, "control flow");
        reportTest(5, "halt and count");
        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/tscCore_vectors.txt ====
// hex words: @00 program, @40 data memory 0..f, @50 output count then test/value pairs
// @70 store count then address/value pairs, @90 final numInst then program length
@00
6012 4134 46FF F6C1 FC1C                    // dependent ALU chain, WWD 0001
FCC0 FD82 FD03 F01C F81C                    // AND, ORR, WWD 1235 1200
6000 4104 8602 7702 FD80 F81C               // store then load-use, WWD 1204
74FF F01C 8405 7701 4610 FE03 F01C          // load into WWD and store, WWD 0a1e
4C00 1302 F41C F41C 0301 FC1C               // BEQ taken on EX result, BNE not taken
7603 0B02 F81C F81C 9024 F41C F41C F81C     // BNE taken on load, JMP, WWD 5555
1B01 FB40 F41C F01D F41C 8500               // BEQ not taken, HLT, words never run
@40
1111 2222 3333 BEEF 4444 0A0A 6666 5555
8888 9999 AAAA BBBB CCCC DDDD EEEE FFFF
@50
0009
0002 0001 0002 1235 0002 1200
0003 1204 0003 BEEF 0003 0A1E
0004 0A0A 0004 5555 0004 5F5F
@70
0002
0006 1200 0009 BEEF
@90
0023 002B
